// ==== hdl/soc_pkg.sv ====
// ----------------------------------------------------------
// CSR subsystem shared definitions
// Bus widths, word and address types, timer register map
// and timer run state
// ----------------------------------------------------------

package soc_pkg;

	// ----------------------------------------------------------
	// CSR bus geometry
	// ----------------------------------------------------------

	// Word address, as seen by every peripheral
	parameter int CSR_ADDR_W = 14;
	// Data word width
	parameter int CSR_DATA_W = 32;
	// Upper address bits selecting a peripheral block
	parameter int CSR_BLK_W = 4;
	// Low address bits selecting a register in a block
	parameter int CSR_REG_W = 2;

	// Full CSR address
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	// One CSR data word
	typedef logic [CSR_DATA_W-1:0] csr_word_t;

	// ----------------------------------------------------------
	// Timer register map
	// ----------------------------------------------------------

	// Register index inside a timer block
	typedef enum logic [CSR_REG_W-1:0] {
		// Bit 0 enable, bit 1 autoreload
		REG_CTRL = 2'd0,
		// Match value
		REG_COMPARE = 2'd1,
		// Current count, writable
		REG_COUNTER = 2'd2,
		// Bit 0 pending, write 1 to clear
		REG_STATUS = 2'd3
	} csr_reg_e;

	// CTRL bit positions
	parameter int CTRL_EN_BIT = 0;
	parameter int CTRL_AUTO_BIT = 1;

	// STATUS bit positions
	parameter int STATUS_PEND_BIT = 0;

	// ----------------------------------------------------------
	// Timer run state
	// ----------------------------------------------------------

	// Idle holds the count, run counts up each cycle
	typedef enum logic {
		TIMER_IDLE = 1'b0,
		TIMER_RUN = 1'b1
	} timer_state_e;

endpackage

// ==== hdl/soc_reset_gen.sv ====
// ----------------------------------------------------------
// Power-on reset generator
// Debounces hard_reset into the system reset and drives
// the active-low peripheral reset pin
// ----------------------------------------------------------

`timescale 1ns/1ps

module soc_reset_gen #(
	parameter int RST_DEBOUNCE_W = 5
) (
	input logic sys_clk,
	input logic hard_reset,
	output logic sys_rst,
	output logic periph_rst_n_o
);

	// Debounce down-counter
	logic [RST_DEBOUNCE_W-1:0] rst_cnt;

	// ----------------------------------------------------------
	// Counter
	// ----------------------------------------------------------

	// Reload on every hard_reset cycle, then drain to zero
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			rst_cnt <= '1;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Reset outputs
	// ----------------------------------------------------------

	// Registered "counter nonzero"
	// Released one cycle after the count runs out
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			sys_rst <= 1'b1;
		end else begin
			sys_rst <= (rst_cnt != '0);
		end
	end

	// External peripherals share the system reset, inverted
	assign periph_rst_n_o = ~sys_rst;

endmodule

// ==== hdl/csr_bridge.sv ====
// ----------------------------------------------------------
// Host to CSR bridge
// Turns a single-cycle host strobe into a registered
// CSR bus cycle one clock later
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst,

	// Host side
	input logic host_stb_i,
	input logic host_we_i,
	input soc_pkg::csr_addr_t host_adr_i,
	input soc_pkg::csr_word_t host_dat_i,

	// CSR bus
	output soc_pkg::csr_addr_t csr_a,
	output logic csr_we,
	output soc_pkg::csr_word_t csr_dw,
	output logic csr_stb
);

	// ----------------------------------------------------------
	// Bus strobe
	// ----------------------------------------------------------

	// One bus cycle per host strobe, no back-pressure
	// Strobes seen during reset are dropped for good
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_stb <= 1'b0;
		end else begin
			csr_stb <= host_stb_i;
		end
	end

	// ----------------------------------------------------------
	// Address, direction and write data
	// ----------------------------------------------------------

	// Captured alongside the strobe
	// Held between accesses, only meaningful while csr_stb is high
	// Back-to-back strobes overwrite these every cycle,
	// so a new access can follow the previous one directly
	always_ff @(posedge sys_clk) begin
		if (host_stb_i) begin
			csr_a <= host_adr_i;
			csr_we <= host_we_i;
			csr_dw <= host_dat_i;
		end
	end

endmodule

// ==== hdl/csr_timer.sv ====
// ----------------------------------------------------------
// Compare-match timer peripheral
// Four CSR registers in its own block, interrupt on a
// counter match, one-shot or autoreload
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_timer #(
	parameter int BLK_ADDR = 1
) (
	input logic sys_clk,
	input logic sys_rst,

	// CSR bus
	input soc_pkg::csr_addr_t csr_a,
	input logic csr_we,
	input soc_pkg::csr_word_t csr_dw,
	input logic csr_stb,
	output soc_pkg::csr_word_t csr_dr,

	// Interrupt, level
	output logic irq
);

	// Block number this timer answers to
	localparam logic [soc_pkg::CSR_BLK_W-1:0] BLK_SEL = BLK_ADDR[soc_pkg::CSR_BLK_W-1:0];

	logic blk_hit;
	soc_pkg::csr_reg_e reg_sel;
	logic wr_en;
	logic rd_en;
	logic match;

	soc_pkg::timer_state_e state;
	logic autoreload;
	soc_pkg::csr_word_t compare;
	soc_pkg::csr_word_t counter;
	logic pending;

	// ----------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------

	// Block from the top bits, register from the bottom two
	// Middle bits ignored, so registers alias within the block
	assign blk_hit = (csr_a[soc_pkg::CSR_ADDR_W-1 -: soc_pkg::CSR_BLK_W] == BLK_SEL);
	assign reg_sel = soc_pkg::csr_reg_e'(csr_a[soc_pkg::CSR_REG_W-1:0]);
	assign wr_en = csr_stb & csr_we & blk_hit;
	assign rd_en = csr_stb & ~csr_we & blk_hit;

	// Running and reached the compare value
	assign match = (state == soc_pkg::TIMER_RUN) && (counter == compare);

	// ----------------------------------------------------------
	// Counter FSM and registers
	// ----------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= soc_pkg::TIMER_IDLE;
			autoreload <= 1'b0;
			compare <= '0;
			counter <= '0;
			pending <= 1'b0;
		end else begin
			// Count, wrap or stop on a match
			if (match) begin
				pending <= 1'b1;
				if (autoreload) begin
					counter <= '0;
				end else begin
					// One-shot, count stays at compare
					state <= soc_pkg::TIMER_IDLE;
				end
			end else if (state == soc_pkg::TIMER_RUN) begin
				counter <= counter + 1'b1;
			end

			// Bus writes override the counting above
			if (wr_en) begin
				case (reg_sel)
					soc_pkg::REG_CTRL: begin
						state <= csr_dw[soc_pkg::CTRL_EN_BIT] ? soc_pkg::TIMER_RUN
							: soc_pkg::TIMER_IDLE;
						autoreload <= csr_dw[soc_pkg::CTRL_AUTO_BIT];
					end
					soc_pkg::REG_COMPARE: compare <= csr_dw;
					soc_pkg::REG_COUNTER: counter <= csr_dw;
					soc_pkg::REG_STATUS: begin
						// A match in the same cycle keeps its event
						if (csr_dw[soc_pkg::STATUS_PEND_BIT] && !match) begin
							pending <= 1'b0;
						end
					end
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// Read data, zero unless this block is read
	// ----------------------------------------------------------

	always_comb begin
		csr_dr = '0;
		if (rd_en) begin
			case (reg_sel)
				soc_pkg::REG_CTRL: begin
					csr_dr[soc_pkg::CTRL_EN_BIT] = (state == soc_pkg::TIMER_RUN);
					csr_dr[soc_pkg::CTRL_AUTO_BIT] = autoreload;
				end
				soc_pkg::REG_COMPARE: csr_dr = compare;
				soc_pkg::REG_COUNTER: csr_dr = counter;
				soc_pkg::REG_STATUS: csr_dr[soc_pkg::STATUS_PEND_BIT] = pending;
			endcase
		end
	end

	// Interrupt follows pending
	assign irq = pending;

endmodule

// ==== hdl/csr_read_collect.sv ====
// ----------------------------------------------------------
// CSR read collector
// ORs peripheral read data, returns data and acknowledge
// to the host and gathers the interrupt lines
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_read_collect #(
	parameter int N_TIMERS = 4
) (
	input logic sys_clk,
	input logic sys_rst,

	// CSR bus side
	input logic csr_stb,
	input soc_pkg::csr_word_t [N_TIMERS-1:0] csr_dr_all,
	input logic [N_TIMERS-1:0] irq_all,

	// Host side
	output logic host_ack_o,
	output soc_pkg::csr_word_t host_dat_o,
	output logic [N_TIMERS-1:0] irq_o
);

	// Combined read word
	soc_pkg::csr_word_t rd_or;

	// ----------------------------------------------------------
	// Read data reduction
	// ----------------------------------------------------------

	// Idle peripherals drive zero, so OR picks the one addressed
	// Nobody answering means zero data
	always_comb begin
		rd_or = '0;
		for (int i = 0; i < N_TIMERS; i++) begin
			rd_or = rd_or | csr_dr_all[i];
		end
	end

	// ----------------------------------------------------------
	// Output registers
	// ----------------------------------------------------------

	// Ack one cycle after the bus strobe, data with it
	// Interrupt vector one cycle behind pending
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			host_ack_o <= 1'b0;
			host_dat_o <= '0;
			irq_o <= '0;
		end else begin
			host_ack_o <= csr_stb;
			host_dat_o <= rd_or;
			irq_o <= irq_all;
		end
	end

endmodule

// ==== hdl/soc_top.sv ====
// ----------------------------------------------------------
// CSR subsystem top level
// Reset generator, host bridge, a row of timer blocks
// and the read collector
// ----------------------------------------------------------

`timescale 1ns/1ps

module soc_top #(
	parameter int N_TIMERS = 4,
	parameter int RST_DEBOUNCE_W = 5
) (
	input logic sys_clk,
	input logic hard_reset,

	// Host access port
	input logic host_stb_i,
	input logic host_we_i,
	input soc_pkg::csr_addr_t host_adr_i,
	input soc_pkg::csr_word_t host_dat_i,
	output logic host_ack_o,
	output soc_pkg::csr_word_t host_dat_o,

	// Interrupts, one bit per timer
	output logic [N_TIMERS-1:0] irq_o,

	// External peripheral reset
	output logic periph_rst_n_o
);

	logic sys_rst;

	// CSR bus
	soc_pkg::csr_addr_t csr_a;
	logic csr_we;
	soc_pkg::csr_word_t csr_dw;
	logic csr_stb;

	// Per-timer read data and interrupts
	soc_pkg::csr_word_t [N_TIMERS-1:0] csr_dr_all;
	logic [N_TIMERS-1:0] irq_all;

	// ----------------------------------------------------------
	// Reset and host bridge
	// ----------------------------------------------------------

	soc_reset_gen #(
		.RST_DEBOUNCE_W(RST_DEBOUNCE_W)
	) u_reset_gen (
		.sys_clk(sys_clk),
		.hard_reset(hard_reset),
		.sys_rst(sys_rst),
		.periph_rst_n_o(periph_rst_n_o)
	);

	csr_bridge u_bridge (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.host_stb_i(host_stb_i),
		.host_we_i(host_we_i),
		.host_adr_i(host_adr_i),
		.host_dat_i(host_dat_i),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_dw(csr_dw),
		.csr_stb(csr_stb)
	);

	// ----------------------------------------------------------
	// Timers, block 0 left unmapped
	// ----------------------------------------------------------

	for (genvar i = 0; i < N_TIMERS; i++) begin : g_timer
		csr_timer #(
			.BLK_ADDR(i + 1)
		) u_timer (
			.sys_clk(sys_clk),
			.sys_rst(sys_rst),
			.csr_a(csr_a),
			.csr_we(csr_we),
			.csr_dw(csr_dw),
			.csr_stb(csr_stb),
			.csr_dr(csr_dr_all[i]),
			.irq(irq_all[i])
		);
	end

	// Read return path
	csr_read_collect #(
		.N_TIMERS(N_TIMERS)
	) u_collect (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_stb(csr_stb),
		.csr_dr_all(csr_dr_all),
		.irq_all(irq_all),
		.host_ack_o(host_ack_o),
		.host_dat_o(host_dat_o),
		.irq_o(irq_o)
	);

endmodule

// ==== verif/tb_soc_top.sv ====
// ----------------------------------------------------------
// Testbench for the CSR subsystem top level
// Table of host accesses and interrupt waits, checked
// against the timer register map and bus timing
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_soc_top;

	localparam int N_TIMERS = 4;
	localparam int RST_DEBOUNCE_W = 5;

	// One cycle limit per kind of wait
	localparam int RST_TIMEOUT = 200;
	localparam int ACK_TIMEOUT = 10;
	localparam int IRQ_TIMEOUT = 200;

	typedef logic [soc_pkg::CSR_BLK_W-1:0] blk_t;
	typedef logic [N_TIMERS-1:0] irq_vec_t;

	// Step kinds
	typedef enum logic [1:0] {
		OP_WR,
		OP_RD,
		OP_IRQ
	} op_e;

	// One table row
	// OP_IRQ uses data bit 0 as the level of the block's bit and exp as the vector
	typedef struct packed {
		op_e op;
		blk_t blk;
		soc_pkg::csr_reg_e rsel;
		soc_pkg::csr_word_t data;
		soc_pkg::csr_word_t exp;
	} step_t;

	logic sys_clk;
	logic hard_reset;
	logic host_stb_i;
	logic host_we_i;
	soc_pkg::csr_addr_t host_adr_i;
	soc_pkg::csr_word_t host_dat_i;
	logic host_ack_o;
	soc_pkg::csr_word_t host_dat_o;
	irq_vec_t irq_o;
	logic periph_rst_n_o;

	step_t steps[$];
	logic [31:0] rng_state;
	// Compare value per block with index 0 unused
	soc_pkg::csr_word_t cmp_val[N_TIMERS+1];
	soc_pkg::csr_word_t load_val;
	soc_pkg::csr_word_t pair_val;
	soc_pkg::csr_word_t rdat;

	soc_top #(
		.N_TIMERS(N_TIMERS),
		.RST_DEBOUNCE_W(RST_DEBOUNCE_W)
	) dut (
		.sys_clk(sys_clk),
		.hard_reset(hard_reset),
		.host_stb_i(host_stb_i),
		.host_we_i(host_we_i),
		.host_adr_i(host_adr_i),
		.host_dat_i(host_dat_i),
		.host_ack_o(host_ack_o),
		.host_dat_o(host_dat_o),
		.irq_o(irq_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// 8 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// ----------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic soc_pkg::csr_word_t rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Compare values kept between 8 and 40
	function automatic soc_pkg::csr_word_t rand_compare();
		return 32'd8 + (rand_word() % 32'd33);
	endfunction

	// Block number on top, register index at the bottom
	function automatic soc_pkg::csr_addr_t csr_addr(input blk_t blk,
		input soc_pkg::csr_reg_e rsel);
		soc_pkg::csr_addr_t a;
		a = '0;
		a[soc_pkg::CSR_ADDR_W-1 -: soc_pkg::CSR_BLK_W] = blk;
		a[soc_pkg::CSR_REG_W-1:0] = rsel;
		return a;
	endfunction

	// Expected CTRL readback with enable while running and autoreload as written
	function automatic soc_pkg::csr_word_t ctrl_value(input soc_pkg::timer_state_e st,
		input logic auto_rl);
		soc_pkg::csr_word_t w;
		w = '0;
		w[soc_pkg::CTRL_EN_BIT] = (st == soc_pkg::TIMER_RUN);
		w[soc_pkg::CTRL_AUTO_BIT] = auto_rl;
		return w;
	endfunction

	// Timer in block n owns irq bit n-1
	function automatic irq_vec_t irq_onehot(input blk_t blk);
		return irq_vec_t'(1) << (blk - 1'b1);
	endfunction

	// ----------------------------------------------------------
	// Compare tasks and timeout report
	// ----------------------------------------------------------

	task automatic check_word(input soc_pkg::csr_word_t got, input soc_pkg::csr_word_t exp,
		input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s, read 0x%08h, expected 0x%08h",
				$time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "CSR data mismatch");
		end
	endtask

	task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s, irq_o %b, expected %b", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "interrupt vector mismatch");
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Fail at time %0t: %s, ack after %0d cycles, expected %0d",
				$time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "ack latency mismatch");
		end
	endtask

	task automatic check_rst_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s, level %b, expected %b", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "reset level mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at time %0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "wait limit reached");
	endtask

	// ----------------------------------------------------------
	// Bus access and waits started 1 ns after a rising edge
	// ----------------------------------------------------------

	// Single strobe, then poll for its ack
	task automatic bus_access(input logic we, input soc_pkg::csr_addr_t adr,
		input soc_pkg::csr_word_t wdat, output soc_pkg::csr_word_t got);
		int cycles;
		cycles = 0;
		host_stb_i = 1'b1;
		host_we_i = we;
		host_adr_i = adr;
		host_dat_i = wdat;
		do begin
			if (cycles >= ACK_TIMEOUT) begin
				report_timeout("host_ack_o");
			end
			@(posedge sys_clk);
			#1;
			host_stb_i = 1'b0;
			cycles++;
		end while (!host_ack_o);
		check_latency(cycles, 2, "single access");
		got = host_dat_o;
	endtask

	// Write then read on consecutive cycles with two acks in order
	task automatic write_read_pair(input soc_pkg::csr_addr_t adr,
		input soc_pkg::csr_word_t wdat);
		int cycles;
		int acks;
		int ack_cycle[2];
		soc_pkg::csr_word_t ack_data[2];
		acks = 0;
		host_stb_i = 1'b1;
		host_we_i = 1'b1;
		host_adr_i = adr;
		host_dat_i = wdat;
		@(posedge sys_clk);
		#1;
		cycles = 1;
		host_we_i = 1'b0;
		host_dat_i = '0;
		while (acks < 2) begin
			if (cycles >= ACK_TIMEOUT) begin
				report_timeout("both acks of the back-to-back pair");
			end
			@(posedge sys_clk);
			#1;
			host_stb_i = 1'b0;
			cycles++;
			if (host_ack_o) begin
				ack_cycle[acks] = cycles;
				ack_data[acks] = host_dat_o;
				acks++;
			end
		end
		check_latency(ack_cycle[0], 2, "back-to-back write");
		check_latency(ack_cycle[1], 3, "back-to-back read");
		check_word(ack_data[0], '0, "back-to-back write ack data");
		check_word(ack_data[1], wdat, "back-to-back read data");
	endtask

	// Poll until the block's irq bit has the given level
	task automatic wait_irq(input blk_t blk, input logic level);
		irq_vec_t mask;
		int cycles;
		mask = irq_onehot(blk);
		cycles = 0;
		while (((irq_o & mask) != '0) != level) begin
			if (cycles >= IRQ_TIMEOUT) begin
				report_timeout("a timer interrupt level");
			end
			@(posedge sys_clk);
			#1;
			cycles++;
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus table
	// ----------------------------------------------------------

	task automatic add_step(input op_e op, input blk_t blk, input soc_pkg::csr_reg_e rsel,
		input soc_pkg::csr_word_t data, input soc_pkg::csr_word_t exp);
		step_t s;
		s.op = op;
		s.blk = blk;
		s.rsel = rsel;
		s.data = data;
		s.exp = exp;
		steps.push_back(s);
	endtask

	task automatic build_table();
		for (int b = 1; b <= N_TIMERS; b++) begin
			cmp_val[b] = rand_compare();
		end
		load_val = rand_word();
		// Top bit set so it differs from every earlier COMPARE value
		pair_val = rand_word() | 32'h8000_0000;

		// Quiet after reset
		add_step(OP_IRQ, blk_t'(1), soc_pkg::REG_STATUS, 32'd0, 32'd0);
		for (int b = 1; b <= N_TIMERS; b++) begin
			add_step(OP_RD, blk_t'(b), soc_pkg::REG_COMPARE, 32'd0, 32'd0);
		end
		// COMPARE write and readback per block
		for (int b = 1; b <= N_TIMERS; b++) begin
			add_step(OP_WR, blk_t'(b), soc_pkg::REG_COMPARE, cmp_val[b], 32'd0);
			add_step(OP_RD, blk_t'(b), soc_pkg::REG_COMPARE, 32'd0, cmp_val[b]);
		end
		// Unmapped blocks answer with zero
		add_step(OP_RD, blk_t'(0), soc_pkg::REG_COMPARE, 32'd0, 32'd0);
		add_step(OP_RD, blk_t'(N_TIMERS + 1), soc_pkg::REG_COMPARE, 32'd0, 32'd0);
		add_step(OP_RD, blk_t'(15), soc_pkg::REG_COMPARE, 32'd0, 32'd0);

		// One-shot on block 1
		add_step(OP_WR, blk_t'(1), soc_pkg::REG_CTRL,
			ctrl_value(soc_pkg::TIMER_RUN, 1'b0), 32'd0);
		add_step(OP_IRQ, blk_t'(1), soc_pkg::REG_STATUS, 32'd1,
			soc_pkg::csr_word_t'(irq_onehot(blk_t'(1))));
		add_step(OP_RD, blk_t'(1), soc_pkg::REG_COUNTER, 32'd0, cmp_val[1]);
		add_step(OP_RD, blk_t'(1), soc_pkg::REG_CTRL, 32'd0,
			ctrl_value(soc_pkg::TIMER_IDLE, 1'b0));
		add_step(OP_RD, blk_t'(1), soc_pkg::REG_STATUS, 32'd0, 32'd1);
		// Write-1-to-clear
		add_step(OP_WR, blk_t'(1), soc_pkg::REG_STATUS, 32'd1, 32'd0);
		add_step(OP_RD, blk_t'(1), soc_pkg::REG_STATUS, 32'd0, 32'd0);
		add_step(OP_IRQ, blk_t'(1), soc_pkg::REG_STATUS, 32'd0, 32'd0);

		// Autoreload on block 2 fires again after a clear
		add_step(OP_WR, blk_t'(2), soc_pkg::REG_CTRL,
			ctrl_value(soc_pkg::TIMER_RUN, 1'b1), 32'd0);
		add_step(OP_RD, blk_t'(2), soc_pkg::REG_CTRL, 32'd0,
			ctrl_value(soc_pkg::TIMER_RUN, 1'b1));
		add_step(OP_IRQ, blk_t'(2), soc_pkg::REG_STATUS, 32'd1,
			soc_pkg::csr_word_t'(irq_onehot(blk_t'(2))));
		add_step(OP_WR, blk_t'(2), soc_pkg::REG_STATUS, 32'd1, 32'd0);
		add_step(OP_IRQ, blk_t'(2), soc_pkg::REG_STATUS, 32'd0, 32'd0);
		add_step(OP_IRQ, blk_t'(2), soc_pkg::REG_STATUS, 32'd1,
			soc_pkg::csr_word_t'(irq_onehot(blk_t'(2))));
		// Stop, load the count, read it back
		add_step(OP_WR, blk_t'(2), soc_pkg::REG_CTRL,
			ctrl_value(soc_pkg::TIMER_IDLE, 1'b0), 32'd0);
		add_step(OP_WR, blk_t'(2), soc_pkg::REG_COUNTER, load_val, 32'd0);
		add_step(OP_RD, blk_t'(2), soc_pkg::REG_COUNTER, 32'd0, load_val);
		add_step(OP_RD, blk_t'(2), soc_pkg::REG_CTRL, 32'd0,
			ctrl_value(soc_pkg::TIMER_IDLE, 1'b0));
		add_step(OP_WR, blk_t'(2), soc_pkg::REG_STATUS, 32'd1, 32'd0);
		add_step(OP_IRQ, blk_t'(2), soc_pkg::REG_STATUS, 32'd0, 32'd0);
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------

	initial begin
		int cycles;
		hard_reset = 1'b1;
		host_stb_i = 1'b0;
		host_we_i = 1'b0;
		host_adr_i = '0;
		host_dat_i = '0;
		rng_state = 32'hbd75_f328;
		build_table();

		// Two cycles of hard_reset, then wait out the debounce
		repeat (2) @(posedge sys_clk);
		#1;
		hard_reset = 1'b0;
		// Peripheral reset still held right after hard_reset drops
		check_rst_level(periph_rst_n_o, 1'b0, "periph_rst_n_o after hard_reset");
		cycles = 0;
		while (periph_rst_n_o !== 1'b1) begin
			if (cycles >= RST_TIMEOUT) begin
				report_timeout("release of periph_rst_n_o");
			end
			@(posedge sys_clk);
			#1;
			cycles++;
		end

		foreach (steps[i]) begin
			if (steps[i].op == OP_WR) begin
				bus_access(1'b1, csr_addr(steps[i].blk, steps[i].rsel),
					steps[i].data, rdat);
				check_word(rdat, steps[i].exp, $sformatf("step %0d write ack data", i));
			end else if (steps[i].op == OP_RD) begin
				bus_access(1'b0, csr_addr(steps[i].blk, steps[i].rsel), '0, rdat);
				check_word(rdat, steps[i].exp, $sformatf("step %0d read", i));
			end else begin
				wait_irq(steps[i].blk, steps[i].data[0]);
				check_irq(irq_o, steps[i].exp[N_TIMERS-1:0],
					$sformatf("step %0d irq", i));
			end
		end

		// Back-to-back strobes on block 3 COMPARE
		write_read_pair(csr_addr(blk_t'(3), soc_pkg::REG_COMPARE), pair_val);

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/soc_pkg.sv
hdl/soc_reset_gen.sv
hdl/csr_bridge.sv
hdl/csr_timer.sv
hdl/csr_read_collect.sv
hdl/soc_top.sv
verif/tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR subsystem testbench with Verilator
# Exit status is nonzero on a build error or a failed check

cd "$(dirname "$0")" &&
verilator --binary --timing \
	--timescale 1ns/1ps \
	-f build.f \
	--top-module tb_soc_top \
	-o tb_soc_top &&
./obj_dir/tb_soc_top ||
{ echo "verilator build or run did not pass" >&2; exit 1; }
